/* rtl/rv_isa_pkg.sv */
`default_nettype none

package rv_isa_pkg;

    localparam int XLEN = 64;   // integer register width

    // major opcode field ir[6:0]
    typedef enum logic [6:0] {
        op_lui    = 7'b0110111,
        op_auipc  = 7'b0010111,
        op_load   = 7'b0000011,
        op_store  = 7'b0100011,
        op_imm    = 7'b0010011,   // addi slti sltiu xori ori andi slli srli srai
        op_imm_32 = 7'b0011011,   // addiw slliw srliw sraiw
        op_reg    = 7'b0110011,
        op_reg_32 = 7'b0111011,   // addw subw sllw srlw sraw
        op_jal    = 7'b1101111,
        op_jalr   = 7'b1100111,
        op_branch = 7'b1100011    // beq bne blt bge bltu bgeu
    } opcode_e;

    // addi x0, x0, 0
    localparam logic [31:0] NOP_INSTR = 32'h0000_0013;

    // fixed 32-bit encodings so pc steps by four
    localparam int unsigned INSTR_BYTES = 4;

endpackage

`default_nettype wire

/* rtl/rv_bus_pkg.sv */
`default_nettype none

package rv_bus_pkg;

    // access size on the data bus, same coding as func3 of loads and stores
    typedef enum logic [2:0] {
        ls_byte   = 3'b000,
        ls_half   = 3'b001,
        ls_word   = 3'b010,
        ls_dword  = 3'b011,
        ls_byte_u = 3'b100,   // load only
        ls_half_u = 3'b101,   // load only
        ls_word_u = 3'b110    // load only
    } ls_size_e;

    // load/store step
    typedef enum logic {
        ls_idle = 1'b0,       // next execute issues the enable
        ls_wait = 1'b1        // enable sent, waiting for done on re-execution
    } ls_state_e;

endpackage

`default_nettype wire

/* rtl/rv_regfile.sv */
`timescale 1ns/1ns
`default_nettype none

module rv_regfile import rv_isa_pkg::*; (
    input  wire             clk,
    input  wire             reset,
    input  wire [4:0]       rs1_addr_i,
    input  wire [4:0]       rs2_addr_i,
    output logic [XLEN-1:0] rs1_data_o,
    output logic [XLEN-1:0] rs2_data_o,
    input  wire             rd_we_i,
    input  wire [4:0]       rd_addr_i,
    input  wire [XLEN-1:0]  rd_wdata_i
);

    logic [XLEN-1:0] regs [32];   // x0..x31

    // async read, operands ready in the execute cycle
    assign rs1_data_o = regs[rs1_addr_i];
    assign rs2_data_o = regs[rs2_addr_i];

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (rd_we_i && rd_addr_i != 5'd0) begin
            regs[rd_addr_i] <= rd_wdata_i;   // x0 never written so it reads zero
        end
    end

endmodule

`default_nettype wire

/* rtl/rv_int_exec.sv */
`timescale 1ns/1ns
`default_nettype none

module rv_int_exec import rv_isa_pkg::*; #(
    parameter int PC_W = 40
) (
    input  wire [31:0]      ir_i,
    input  wire [PC_W-1:0]  pc_i,          // already instruction address plus four
    input  wire             ex_valid_i,
    input  wire [XLEN-1:0]  rs1_data_i,
    input  wire [XLEN-1:0]  rs2_data_i,
    output logic            int_we_o,
    output logic [XLEN-1:0] int_wdata_o,
    output logic            redirect_o,
    output logic [PC_W-1:0] redirect_pc_o
);

    opcode_e         opcode;
    logic [2:0]      func3;
    logic [6:0]      func7;
    logic [XLEN-1:0] imm_u;
    logic [XLEN-1:0] imm_i;
    logic [XLEN-1:0] imm_j;
    logic [XLEN-1:0] imm_b;
    logic [PC_W-1:0] instr_pc;
    logic [XLEN-1:0] link;
    logic [XLEN-1:0] op_b;
    logic            is_reg;
    logic            is_sub;
    logic [XLEN-1:0] sum;
    logic [XLEN-1:0] sra_d;
    logic [31:0]     sra_w;
    logic [XLEN-1:0] alu_d;
    logic [31:0]     alu_w;
    logic [XLEN-1:0] jalr_sum;
    logic            taken;

    assign opcode = opcode_e'(ir_i[6:0]);
    assign func3  = ir_i[14:12];
    assign func7  = ir_i[31:25];

    // immediates, all sign extended from ir[31]
    assign imm_u = {{32{ir_i[31]}}, ir_i[31:12], 12'b0};
    assign imm_i = {{52{ir_i[31]}}, ir_i[31:20]};
    assign imm_j = {{43{ir_i[31]}}, ir_i[19:12], ir_i[20], ir_i[30:21], 1'b0};
    assign imm_b = {{51{ir_i[31]}}, ir_i[7], ir_i[30:25], ir_i[11:8], 1'b0};

    assign instr_pc = pc_i - PC_W'(INSTR_BYTES);   // fetch runs one ahead
    assign link     = XLEN'(pc_i);                 // return address = instr_pc + 4

    // second operand is rs2 for register forms, imm_i otherwise
    assign is_reg = (opcode == op_reg) || (opcode == op_reg_32);
    assign op_b   = is_reg ? rs2_data_i : imm_i;
    assign is_sub = is_reg && func7[5];            // addi has no sub form
    assign sum    = is_sub ? rs1_data_i - op_b : rs1_data_i + op_b;

    // arithmetic shifts kept apart so the signedness survives
    assign sra_d = $signed(rs1_data_i) >>> op_b[5:0];
    assign sra_w = $signed(rs1_data_i[31:0]) >>> op_b[4:0];

    always_comb begin
        case (func3)
            3'b000: alu_d = sum;
            3'b001: alu_d = rs1_data_i << op_b[5:0];
            3'b010: alu_d = {63'b0, $signed(rs1_data_i) < $signed(op_b)};
            3'b011: alu_d = {63'b0, rs1_data_i < op_b};
            3'b100: alu_d = rs1_data_i ^ op_b;
            3'b101: alu_d = func7[5] ? sra_d : rs1_data_i >> op_b[5:0];   // srai: ir[30]
            3'b110: alu_d = rs1_data_i | op_b;
            default: alu_d = rs1_data_i & op_b;
        endcase
    end

    // word forms, 5-bit shift amount
    always_comb begin
        case (func3)
            3'b001: alu_w = rs1_data_i[31:0] << op_b[4:0];
            3'b101: alu_w = func7[5] ? sra_w : rs1_data_i[31:0] >> op_b[4:0];
            default: alu_w = sum[31:0];   // addw addiw subw
        endcase
    end

    assign jalr_sum = rs1_data_i + imm_i;

    always_comb begin
        case (func3)
            3'b000: taken = rs1_data_i == rs2_data_i;                    // beq
            3'b001: taken = rs1_data_i != rs2_data_i;                    // bne
            3'b100: taken = $signed(rs1_data_i) < $signed(rs2_data_i);   // blt
            3'b101: taken = $signed(rs1_data_i) >= $signed(rs2_data_i);  // bge
            3'b110: taken = rs1_data_i < rs2_data_i;                     // bltu
            3'b111: taken = rs1_data_i >= rs2_data_i;                    // bgeu
            default: taken = 1'b0;
        endcase
    end

    always_comb begin
        int_we_o      = 1'b0;
        int_wdata_o   = alu_d;
        redirect_o    = 1'b0;
        redirect_pc_o = instr_pc + imm_b[PC_W-1:0];
        if (ex_valid_i) begin   // nothing in a bubble
            case (opcode)
                op_lui: begin
                    int_we_o    = 1'b1;
                    int_wdata_o = imm_u;
                end
                op_auipc: begin
                    int_we_o    = 1'b1;
                    int_wdata_o = XLEN'(instr_pc) + imm_u;
                end
                op_imm, op_reg: int_we_o = 1'b1;
                op_imm_32, op_reg_32: begin
                    int_we_o    = 1'b1;
                    int_wdata_o = {{32{alu_w[31]}}, alu_w};   // sign extend word result
                end
                op_jal: begin
                    int_we_o      = 1'b1;
                    int_wdata_o   = link;
                    redirect_o    = 1'b1;
                    redirect_pc_o = instr_pc + imm_j[PC_W-1:0];
                end
                op_jalr: begin
                    int_we_o      = 1'b1;
                    int_wdata_o   = link;
                    redirect_o    = 1'b1;
                    redirect_pc_o = {jalr_sum[PC_W-1:1], 1'b0};   // bit 0 cleared
                end
                op_branch: redirect_o = taken;
                default: ;   // load/store handled in lsu, unknown words are no-ops
            endcase
        end
    end

endmodule

`default_nettype wire

/* rtl/rv_lsu.sv */
`timescale 1ns/1ns
`default_nettype none

module rv_lsu import rv_isa_pkg::*; import rv_bus_pkg::*; #(
    parameter int ADDR_W = 39
) (
    input  wire              clk,
    input  wire              reset,
    input  wire [31:0]       ir_i,
    input  wire              ex_valid_i,
    input  wire [XLEN-1:0]   rs1_data_i,
    input  wire [XLEN-1:0]   rs2_data_i,
    input  wire              bus_read_done_i,    // level
    input  wire              bus_write_done_i,   // level
    input  wire [XLEN-1:0]   bus_read_data_i,
    output logic [ADDR_W-1:0] bus_address_o,
    output logic [XLEN-1:0]  bus_write_data_o,
    output logic             bus_write_enable_o, // one-cycle pulse
    output logic             bus_read_enable_o,  // one-cycle pulse
    output ls_size_e         bus_ls_type_o,
    output logic             ls_hold_o,
    output logic             ld_we_o,
    output logic [XLEN-1:0]  ld_wdata_o
);

    opcode_e         opcode;
    ls_size_e        size;
    ls_state_e       state;
    logic            is_load;
    logic            is_store;
    logic            is_ls;
    logic [XLEN-1:0] imm_i;
    logic [XLEN-1:0] imm_s;
    logic [XLEN-1:0] eff_addr;
    logic [XLEN-1:0] store_data;
    logic            done;
    logic            start;
    logic            finish;

    assign opcode = opcode_e'(ir_i[6:0]);
    assign size   = ls_size_e'(ir_i[14:12]);   // func3

    assign is_load  = ex_valid_i && (opcode == op_load);
    assign is_store = ex_valid_i && (opcode == op_store);
    assign is_ls    = is_load || is_store;

    assign imm_i    = {{52{ir_i[31]}}, ir_i[31:20]};
    assign imm_s    = {{52{ir_i[31]}}, ir_i[31:25], ir_i[11:7]};
    assign eff_addr = rs1_data_i + (is_store ? imm_s : imm_i);

    // store data zero extended from the access width
    always_comb begin
        case (size)
            ls_byte: store_data = {56'b0, rs2_data_i[7:0]};
            ls_half: store_data = {48'b0, rs2_data_i[15:0]};
            ls_word: store_data = {32'b0, rs2_data_i[31:0]};
            default: store_data = rs2_data_i;
        endcase
    end

    // load extension by func3
    always_comb begin
        case (size)
            ls_byte:   ld_wdata_o = {{56{bus_read_data_i[7]}}, bus_read_data_i[7:0]};
            ls_half:   ld_wdata_o = {{48{bus_read_data_i[15]}}, bus_read_data_i[15:0]};
            ls_word:   ld_wdata_o = {{32{bus_read_data_i[31]}}, bus_read_data_i[31:0]};
            ls_byte_u: ld_wdata_o = {56'b0, bus_read_data_i[7:0]};
            ls_half_u: ld_wdata_o = {48'b0, bus_read_data_i[15:0]};
            ls_word_u: ld_wdata_o = {32'b0, bus_read_data_i[31:0]};
            default:   ld_wdata_o = bus_read_data_i;   // ld
        endcase
    end

    assign done   = is_store ? bus_write_done_i : bus_read_done_i;   // matching level only
    assign start  = is_ls && (state == ls_idle);
    assign finish = is_ls && (state == ls_wait) && done;

    // hold re-fetches this instruction until the access finishes
    assign ls_hold_o = is_ls && !finish;
    assign ld_we_o   = is_load && finish;

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            state              <= ls_idle;
            bus_read_enable_o  <= 1'b0;
            bus_write_enable_o <= 1'b0;
        end else begin
            bus_read_enable_o  <= start && is_load;    // pulse on first execute only
            bus_write_enable_o <= start && is_store;
            if (start) begin
                state <= ls_wait;
            end else if (finish) begin
                state <= ls_idle;
            end
        end
    end

    // address, data and type held until the next access
    always_ff @(posedge clk) begin
        if (start) begin
            bus_address_o    <= eff_addr[ADDR_W-1:0];
            bus_write_data_o <= store_data;
            bus_ls_type_o    <= size;
        end
    end

endmodule

`default_nettype wire

/* rtl/rv_commit.sv */
`timescale 1ns/1ns
`default_nettype none

module rv_commit import rv_isa_pkg::*; #(
    parameter logic [XLEN-1:0] RESET_PC = 64'h8000_0000,
    parameter int              PC_W     = 40
) (
    input  wire             clk,
    input  wire             reset,
    input  wire [31:0]      instruction_i,   // word at pc_o
    input  wire             ls_hold_i,
    input  wire             redirect_i,
    input  wire [PC_W-1:0]  redirect_pc_i,
    input  wire             int_we_i,
    input  wire [XLEN-1:0]  int_wdata_i,
    input  wire             ld_we_i,
    input  wire [XLEN-1:0]  ld_wdata_i,
    input  wire [31:0]      ir_i,            // executing instruction
    output logic [PC_W-1:0] pc_o,
    output logic [31:0]     ir_o,
    output logic            ex_valid_o,
    output logic            rd_we_o,
    output logic [4:0]      rd_addr_o,
    output logic [XLEN-1:0] rd_wdata_o
);

    logic bubble;   // ir holds a wrong-path fetch

    assign ex_valid_o = !bubble;

    // write-back merge
    // int and load sources come from disjoint opcodes so they never collide
    assign rd_we_o    = int_we_i || ld_we_i;
    assign rd_wdata_o = ld_we_i ? ld_wdata_i : int_wdata_i;
    assign rd_addr_o  = ir_i[11:7];

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            pc_o   <= RESET_PC[PC_W-1:0];
            ir_o   <= NOP_INSTR;
            bubble <= 1'b0;
        end else begin
            ir_o <= instruction_i;   // fetch register, every cycle
            if (ls_hold_i) begin
                // back to the instruction's own address
                pc_o   <= pc_o - PC_W'(INSTR_BYTES);
                bubble <= 1'b1;
            end else if (redirect_i) begin
                pc_o   <= redirect_pc_i;   // jump or taken branch
                bubble <= 1'b1;
            end else begin
                pc_o   <= pc_o + PC_W'(INSTR_BYTES);
                bubble <= 1'b0;            // bubble lasts one cycle
            end
        end
    end

endmodule

`default_nettype wire

/* rtl/rv_core.sv */
`timescale 1ns/1ns
`default_nettype none

module rv_core import rv_isa_pkg::*; import rv_bus_pkg::*; #(
    parameter logic [XLEN-1:0] RESET_PC = 64'h8000_0000,
    parameter int              PC_W     = 40,
    parameter int              ADDR_W   = 39   // sv39 sized bus address
) (
    input  wire               clk,
    input  wire               reset,
    input  wire [31:0]        instruction_i,
    input  wire               bus_read_done_i,
    input  wire               bus_write_done_i,
    input  wire [XLEN-1:0]    bus_read_data_i,
    output logic [PC_W-1:0]   pc_o,
    output logic [31:0]       ir_o,
    output logic [ADDR_W-1:0] bus_address_o,
    output logic [XLEN-1:0]   bus_write_data_o,
    output logic              bus_write_enable_o,
    output logic              bus_read_enable_o,
    output ls_size_e          bus_ls_type_o
);

    logic            ex_valid;
    logic [XLEN-1:0] rs1_data;
    logic [XLEN-1:0] rs2_data;
    logic            int_we;
    logic [XLEN-1:0] int_wdata;
    logic            redirect;
    logic [PC_W-1:0] redirect_pc;
    logic            ls_hold;
    logic            ld_we;
    logic [XLEN-1:0] ld_wdata;
    logic            rd_we;
    logic [4:0]      rd_addr;
    logic [XLEN-1:0] rd_wdata;

    // register addresses straight from the ir fields
    rv_regfile u_regfile (
        .clk        (clk),
        .reset      (reset),
        .rs1_addr_i (ir_o[19:15]),
        .rs2_addr_i (ir_o[24:20]),
        .rs1_data_o (rs1_data),
        .rs2_data_o (rs2_data),
        .rd_we_i    (rd_we),
        .rd_addr_i  (rd_addr),
        .rd_wdata_i (rd_wdata)
    );

    rv_int_exec #(
        .PC_W (PC_W)
    ) u_int_exec (
        .ir_i          (ir_o),
        .pc_i          (pc_o),
        .ex_valid_i    (ex_valid),
        .rs1_data_i    (rs1_data),
        .rs2_data_i    (rs2_data),
        .int_we_o      (int_we),
        .int_wdata_o   (int_wdata),
        .redirect_o    (redirect),
        .redirect_pc_o (redirect_pc)
    );

    rv_lsu #(
        .ADDR_W (ADDR_W)
    ) u_lsu (
        .clk                (clk),
        .reset              (reset),
        .ir_i               (ir_o),
        .ex_valid_i         (ex_valid),
        .rs1_data_i         (rs1_data),
        .rs2_data_i         (rs2_data),
        .bus_read_done_i    (bus_read_done_i),
        .bus_write_done_i   (bus_write_done_i),
        .bus_read_data_i    (bus_read_data_i),
        .bus_address_o      (bus_address_o),
        .bus_write_data_o   (bus_write_data_o),
        .bus_write_enable_o (bus_write_enable_o),
        .bus_read_enable_o  (bus_read_enable_o),
        .bus_ls_type_o      (bus_ls_type_o),
        .ls_hold_o          (ls_hold),
        .ld_we_o            (ld_we),
        .ld_wdata_o         (ld_wdata)
    );

    rv_commit #(
        .RESET_PC (RESET_PC),
        .PC_W     (PC_W)
    ) u_commit (
        .clk           (clk),
        .reset         (reset),
        .instruction_i (instruction_i),
        .ls_hold_i     (ls_hold),
        .redirect_i    (redirect),
        .redirect_pc_i (redirect_pc),
        .int_we_i      (int_we),
        .int_wdata_i   (int_wdata),
        .ld_we_i       (ld_we),
        .ld_wdata_i    (ld_wdata),
        .ir_i          (ir_o),        // rd field of the executing instruction
        .pc_o          (pc_o),
        .ir_o          (ir_o),
        .ex_valid_o    (ex_valid),
        .rd_we_o       (rd_we),
        .rd_addr_o     (rd_addr),
        .rd_wdata_o    (rd_wdata)
    );

endmodule

`default_nettype wire

/* sim/tb_rv_core_assert.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_rv_core_assert (
    input wire       clk,
    input wire       reset,
    input wire       rd_en_i,
    input wire       wr_en_i,
    input wire [2:0] ls_type_i
);

    // read and write never share a cycle
    a_excl: assert property (@(posedge clk) disable iff (!reset) !(rd_en_i && wr_en_i))
        else $error("read and write enable high together");

    // enables are single-cycle pulses
    a_rd_pulse: assert property (@(posedge clk) disable iff (!reset) rd_en_i |=> !rd_en_i)
        else $error("read enable held longer than one cycle");
    a_wr_pulse: assert property (@(posedge clk) disable iff (!reset) wr_en_i |=> !wr_en_i)
        else $error("write enable held longer than one cycle");

    a_reset_quiet: assert property (@(posedge clk) !reset |-> !rd_en_i && !wr_en_i)
        else $error("bus enable high during reset");

    // 3'b111 is not an access size
    a_type_ok: assert property (@(posedge clk) disable iff (!reset)
        (rd_en_i || wr_en_i) |-> (!$isunknown(ls_type_i) && ls_type_i != 3'b111))
        else $error("undefined access size with an enable high");

endmodule

bind rv_core tb_rv_core_assert u_assert (
    .clk       (clk),
    .reset     (reset),
    .rd_en_i   (bus_read_enable_o),
    .wr_en_i   (bus_write_enable_o),
    .ls_type_i (bus_ls_type_o)
);

`default_nettype wire

/* sim/tb_rv_core.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_rv_core import rv_isa_pkg::*; import rv_bus_pkg::*; ();

    localparam logic [63:0] RESET_PC = 64'h8000_0000;
    localparam logic [63:0] DBASE    = 64'h1_0000;   // x31 after lui

    logic clk = 1'b0;
    logic reset;
    logic [31:0] instruction_i;
    logic bus_read_done_i;
    logic bus_write_done_i;
    logic [63:0] bus_read_data_i;
    logic [39:0] pc_o;
    logic [31:0] ir_o;
    logic [38:0] bus_address_o;
    logic [63:0] bus_write_data_o;
    logic bus_write_enable_o;
    logic bus_read_enable_o;
    ls_size_e bus_ls_type_o;

    integer seed;
    int cycles = 0;
    int limit = 1000;
    logic [31:0] imem[$];                 // program, word per pc step
    logic [63:0] dmem[logic [38:0]];      // sparse data memory
    logic [38:0] exp_waddr[$];
    logic [63:0] exp_wdata[$];
    logic [2:0] exp_wtype[$];
    logic [38:0] exp_raddr[$];
    logic [2:0] exp_rtype[$];
    int slot = 0;
    logic rd_s, wr_s, pending, pend_rd;
    logic [38:0] a_s;
    int wait_cnt;

    rv_core #(.RESET_PC(RESET_PC)) u_dut (.*);

    always #10 clk = ~clk;

    task automatic fail_now(input string msg);
        $display("%s", msg);
        $display("TEST FAIL");
        $fatal(1);
    endtask

    function automatic logic [63:0] sext12(input logic [11:0] v);
        return {{52{v[11]}}, v};
    endfunction

    // expected integer result from the ISA rules
    function automatic logic [63:0] ref_alu(input opcode_e op, input logic [2:0] f3,
                                            input logic [6:0] f7, input logic [63:0] a,
                                            input logic [63:0] b);
        logic word;
        logic [5:0] sh;
        logic [31:0] w;
        logic [63:0] r;
        word = (op == op_imm_32) || (op == op_reg_32);
        sh = word ? {1'b0, b[4:0]} : b[5:0];
        case (f3)
            3'd0: r = ((op == op_reg || op == op_reg_32) && f7[5]) ? a - b : a + b;
            3'd1: r = a << sh;
            3'd2: r = ($signed(a) < $signed(b)) ? 64'd1 : 64'd0;
            3'd3: r = (a < b) ? 64'd1 : 64'd0;
            3'd4: r = a ^ b;
            3'd5: begin
                if (word && f7[5]) begin
                    w = $signed(a[31:0]) >>> sh;
                    r = {32'b0, w};
                end else if (word) begin
                    r = {32'b0, a[31:0] >> sh};
                end else if (f7[5]) begin
                    r = $signed(a) >>> sh;
                end else begin
                    r = a >> sh;
                end
            end
            3'd6: r = a | b;
            default: r = a & b;
        endcase
        if (word) r = {{32{r[31]}}, r[31:0]};   // word results sign extended
        return r;
    endfunction

    function automatic logic [63:0] load_ext(input logic [2:0] f3, input logic [63:0] d);
        case (f3)
            3'd0: return {{56{d[7]}}, d[7:0]};
            3'd1: return {{48{d[15]}}, d[15:0]};
            3'd2: return {{32{d[31]}}, d[31:0]};
            3'd4: return {56'b0, d[7:0]};
            3'd5: return {48'b0, d[15:0]};
            3'd6: return {32'b0, d[31:0]};
            default: return d;
        endcase
    endfunction

    function automatic logic branch_taken(input logic [2:0] f3, input logic [63:0] a, b);
        case (f3)
            3'd0: return a == b;
            3'd1: return a != b;
            3'd4: return $signed(a) < $signed(b);
            3'd5: return $signed(a) >= $signed(b);
            3'd6: return a < b;
            default: return a >= b;
        endcase
    endfunction

    function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2, rs1,
                                          input logic [2:0] f3, input logic [4:0] rd,
                                          input opcode_e op);
        return {f7, rs2, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                          input logic [2:0] f3, input logic [4:0] rd,
                                          input opcode_e op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2, rs1,
                                          input logic [2:0] f3);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], op_store};
    endfunction

    function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [4:0] rs2, rs1,
                                          input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], op_branch};
    endfunction

    function automatic logic [31:0] enc_j(input logic [20:0] imm, input logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, op_jal};
    endfunction

    function automatic logic [63:0] next_pc();
        return RESET_PC + 64'(4 * imem.size());
    endfunction

    // store rs2 into the next result slot, expected only when it executes
    task automatic put_store(input logic [4:0] rs2, input logic [2:0] f3,
                             input logic [63:0] data, input logic expect_it);
        logic [11:0] off;
        off = 12'h400 + 12'(8 * slot);
        slot++;
        imem.push_back(enc_s(off, rs2, 5'd31, f3));
        if (expect_it) begin
            exp_waddr.push_back(39'(DBASE + 64'(off)));
            exp_wdata.push_back(data);
            exp_wtype.push_back(f3);
        end
    endtask

    task automatic put_load(input logic [11:0] off, input logic [2:0] f3, input logic [4:0] rd);
        imem.push_back(enc_i(off, 5'd31, f3, rd, op_load));
        exp_raddr.push_back(39'(DBASE + 64'(off)));
        exp_rtype.push_back(f3);
    endtask

    task automatic build_program();
        logic [63:0] a, b, v5, v6, p;
        logic [11:0] iw;
        logic [2:0] f3;
        logic [6:0] f7;
        logic [2:0] bf3 [6];
        for (int k = 0; k < 9; k++) begin
            dmem[39'(DBASE + 64'(8 * k))] = {$random(seed), $random(seed)};
        end
        a = dmem[39'(DBASE)];
        b = dmem[39'(DBASE + 8)];
        imem.push_back({20'h10, 5'd31, op_lui});
        put_store(5'd31, 3'd3, DBASE, 1'b1);
        put_load(12'd0, 3'd3, 5'd1);
        put_load(12'd8, 3'd3, 5'd2);
        // register ops, sub and sra as the last two
        for (int k = 0; k < 10; k++) begin
            f3 = (k < 8) ? 3'(k) : ((k == 8) ? 3'd0 : 3'd5);
            f7 = (k < 8) ? 7'd0 : 7'h20;
            imem.push_back(enc_r(f7, 5'd2, 5'd1, f3, 5'd3, op_reg));
            put_store(5'd3, 3'd3, ref_alu(op_reg, f3, f7, a, b), 1'b1);
        end
        for (int k = 0; k < 5; k++) begin   // addw subw sllw srlw sraw
            f3 = (k < 2) ? 3'd0 : ((k == 2) ? 3'd1 : 3'd5);
            f7 = (k == 1 || k == 4) ? 7'h20 : 7'd0;
            imem.push_back(enc_r(f7, 5'd2, 5'd1, f3, 5'd3, op_reg_32));
            put_store(5'd3, 3'd3, ref_alu(op_reg_32, f3, f7, a, b), 1'b1);
        end
        for (int k = 0; k < 9; k++) begin   // immediates, srai last
            f3 = (k < 8) ? 3'(k) : 3'd5;
            iw = 12'($random(seed));
            if (f3 == 3'd1 || f3 == 3'd5) iw = {(k == 8) ? 6'b010000 : 6'b0, iw[5:0]};
            imem.push_back(enc_i(iw, 5'd1, f3, 5'd3, op_imm));
            put_store(5'd3, 3'd3, ref_alu(op_imm, f3, iw[11:5], a, sext12(iw)), 1'b1);
        end
        for (int k = 0; k < 4; k++) begin   // addiw slliw srliw sraiw
            f3 = (k == 0) ? 3'd0 : ((k == 1) ? 3'd1 : 3'd5);
            iw = 12'($random(seed));
            if (k > 0) iw = {(k == 3) ? 7'b0100000 : 7'b0, iw[4:0]};
            imem.push_back(enc_i(iw, 5'd1, f3, 5'd3, op_imm_32));
            put_store(5'd3, 3'd3, ref_alu(op_imm_32, f3, iw[11:5], a, sext12(iw)), 1'b1);
        end
        for (int k = 0; k < 7; k++) begin   // all load sizes, stored back whole
            put_load(12'(16 + 8 * k), 3'(k), 5'd4);
            put_store(5'd4, 3'd3, load_ext(3'(k), dmem[39'(DBASE + 64'(16 + 8 * k))]), 1'b1);
        end
        for (int k = 0; k < 4; k++) begin   // sb sh sw sd of x1, zero extended
            put_store(5'd1, 3'(k), load_ext(3'(k + 4), a), 1'b1);
        end
        imem.push_back(enc_i(12'hfff, 5'd0, 3'd0, 5'd5, op_imm));   // x5 = -1
        imem.push_back(enc_i(12'd1, 5'd0, 3'd0, 5'd6, op_imm));     // x6 = 1
        v5 = '1;
        v6 = 64'd1;
        bf3 = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};
        foreach (bf3[i]) begin
            for (int k = 0; k < 3; k++) begin
                // operand pairs (x5,x6) (x6,x5) (x6,x6)
                a = (k == 0) ? v5 : v6;
                b = (k == 1) ? v5 : v6;
                imem.push_back(enc_b(13'd8, (k == 1) ? 5'd5 : 5'd6, (k == 0) ? 5'd5 : 5'd6,
                                     bf3[i]));
                put_store(5'd6, 3'd3, v6, !branch_taken(bf3[i], a, b));   // skipped if taken
            end
        end
        p = next_pc();
        imem.push_back(enc_j(21'd8, 5'd8));
        imem.push_back(enc_s(12'h7f8, 5'd0, 5'd31, 3'd3));   // marker, jumped over
        put_store(5'd8, 3'd3, p + 64'd4, 1'b1);
        p = next_pc();
        imem.push_back({20'd0, 5'd9, op_auipc});
        imem.push_back(enc_i(12'd17, 5'd9, 3'd0, 5'd10, op_jalr));   // odd target, bit 0 drops
        imem.push_back(enc_s(12'h7f8, 5'd0, 5'd31, 3'd3));
        imem.push_back(enc_s(12'h7f8, 5'd0, 5'd31, 3'd3));
        put_store(5'd10, 3'd3, p + 64'd8, 1'b1);
        put_store(5'd9, 3'd3, p, 1'b1);
        imem.push_back(enc_j(21'd0, 5'd0));   // spin here
    endtask

    function automatic logic [31:0] fetch_word(input logic [39:0] pc);
        logic [39:0] idx;
        idx = (pc - RESET_PC[39:0]) >> 2;
        return (idx < 40'(imem.size())) ? imem[idx] : NOP_INSTR;
    endfunction

    // instruction memory, driven after the edge
    always @(posedge clk) begin
        #1 instruction_i = fetch_word(pc_o);
    end

    // data memory with a random done delay of 0 to 5 cycles
    always @(posedge clk) begin
        rd_s = bus_read_enable_o;
        wr_s = bus_write_enable_o;
        a_s = bus_address_o;
        #1;
        if (rd_s || wr_s) begin
            bus_read_done_i = 1'b0;   // done drops after the next enable
            bus_write_done_i = 1'b0;
            pending = 1'b1;
            pend_rd = rd_s;
            wait_cnt = $unsigned($random(seed)) % 6;
            if (wr_s) dmem[a_s] = bus_write_data_o;
        end
        if (pending && wait_cnt == 0) begin
            pending = 1'b0;
            if (pend_rd) begin
                // unset words get a fill derived from the full address
                bus_read_data_i = dmem.exists(a_s) ? dmem[a_s] : {25'h0, a_s} ^ 64'ha5a5_5a5a;
                bus_read_done_i = 1'b1;
            end else begin
                bus_write_done_i = 1'b1;
            end
        end else if (pending) begin
            wait_cnt--;
        end
    end

    // compare bus accesses against the expectation queues
    always @(posedge clk) begin
        if (reset && bus_write_enable_o) begin
            assert (exp_waddr.size() > 0) else fail_now("store seen with none expected");
            assert (bus_address_o == exp_waddr[0])
                else fail_now($sformatf("mismatch bus_address_o got %h exp %h",
                                        bus_address_o, exp_waddr[0]));
            assert (bus_write_data_o == exp_wdata[0])
                else fail_now($sformatf("mismatch bus_write_data_o got %h exp %h",
                                        bus_write_data_o, exp_wdata[0]));
            assert (bus_ls_type_o == exp_wtype[0])
                else fail_now($sformatf("mismatch bus_ls_type_o got %h exp %h",
                                        bus_ls_type_o, exp_wtype[0]));
            void'(exp_waddr.pop_front());
            void'(exp_wdata.pop_front());
            void'(exp_wtype.pop_front());
        end
        if (reset && bus_read_enable_o) begin
            assert (exp_raddr.size() > 0) else fail_now("load seen with none expected");
            assert (bus_address_o == exp_raddr[0])
                else fail_now($sformatf("mismatch bus_address_o got %h exp %h",
                                        bus_address_o, exp_raddr[0]));
            assert (bus_ls_type_o == exp_rtype[0])
                else fail_now($sformatf("mismatch bus_ls_type_o got %h exp %h",
                                        bus_ls_type_o, exp_rtype[0]));
            void'(exp_raddr.pop_front());
            void'(exp_rtype.pop_front());
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > limit) fail_now("timeout, the program did not finish its stores");
    end

    initial begin
        seed = 43;
        reset = 1'b0;
        instruction_i = NOP_INSTR;
        bus_read_done_i = 1'b0;
        bus_write_done_i = 1'b0;
        bus_read_data_i = '0;
        pending = 1'b0;
        build_program();
        limit = 30 * imem.size();
        instruction_i = fetch_word(RESET_PC[39:0]);
        repeat (4) @(posedge clk);
        #1 reset = 1'b1;
        assert (pc_o == RESET_PC[39:0])
            else fail_now($sformatf("mismatch pc_o got %h exp %h", pc_o, RESET_PC[39:0]));
        // ir comes out of reset as addi x0, x0, 0
        assert (ir_o == enc_i(12'd0, 5'd0, 3'd0, 5'd0, op_imm))
            else fail_now($sformatf("mismatch ir_o got %h exp %h", ir_o,
                                    enc_i(12'd0, 5'd0, 3'd0, 5'd0, op_imm)));
        while (exp_waddr.size() != 0) begin
            @(posedge clk);
        end
        repeat (20) @(posedge clk);   // room for a stray marker store
        if (exp_raddr.size() == 0) begin
            $display("TEST PASS");
            $finish;
        end else begin
            fail_now("not every expected load reached the bus");
        end
    end

endmodule

`default_nettype wire

/* filelist.f */
rtl/rv_isa_pkg.sv
rtl/rv_bus_pkg.sv
rtl/rv_regfile.sv
rtl/rv_int_exec.sv
rtl/rv_lsu.sv
rtl/rv_commit.sv
rtl/rv_core.sv
sim/tb_rv_core_assert.sv
sim/tb_rv_core.sv

/* Makefile */
.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wall -Wno-fatal -f filelist.f \
		--top-module tb_rv_core -Mdir obj_dir -o tb_rv_core

run: compile
	-./obj_dir/tb_rv_core > sim.log 2>&1
	cat sim.log
	grep -q "TEST PASS" sim.log

clean:
	rm -rf obj_dir sim.log
